// ==== Makefile ====
# Verilator flow for the float to int converter testbench

VERILATOR ?= verilator
TOP       ?= tb_fp_to_int_cvt
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/cvt_align.sv ====
`timescale 1ns/1ps
`include "cvt_config.svh"

// moves the mantissa so that the binary point sits between
// mant[W] and mant[W-1] of the 2W+1 bit field
module cvt_align (
    input  cvt_pkg::unpack_t stage_i,
    output cvt_pkg::align_t  stage_o
);

    localparam int W  = `CVT_INT_WIDTH;
    localparam int MB = `CVT_MAN_BITS;
    localparam int EW = `CVT_EXP_WIDTH;
    localparam int SW = `CVT_SHIFT_WIDTH;

    logic [2*W:0]          preshift;
    logic [SW-1:0]         shamt;
    logic                  of_before_round;
    logic signed [EW-1:0]  ovf_limit;

    // hidden bit lands on 2^(W-1), one spare integer bit above for the carry
    assign preshift = {1'b0, stage_i.mantissa, {(2*W-MB-1){1'b0}}};

    // unsigned range is one binade larger
    assign ovf_limit = EW'(W - 1) + EW'(stage_i.is_unsigned);

    always_comb begin
        of_before_round = 1'b0;
        shamt           = '0;
        if ($signed(stage_i.exponent) >= ovf_limit) begin
            of_before_round = 1'b1;  // keep shamt at zero
        end else if ($signed(stage_i.exponent) < -1) begin
            // below one half, everything ends up in sticky
            shamt = SW'(W + 1);
        end else begin
            shamt = SW'(W - 1) - SW'(stage_i.exponent);
        end
    end

    always_comb begin
        stage_o.tag             = stage_i.tag;
        stage_o.is_unsigned     = stage_i.is_unsigned;
        stage_o.rnd_mode        = stage_i.rnd_mode;
        stage_o.clss            = stage_i.clss;
        stage_o.sign            = stage_i.sign;
        stage_o.mant            = preshift >> shamt;
        stage_o.of_before_round = of_before_round;
    end

endmodule

// ==== logic/cvt_config.svh ====
`ifndef CVT_CONFIG_SVH
`define CVT_CONFIG_SVH

// single precision source format
`define CVT_EXP_BITS    8
`define CVT_MAN_BITS    23
`define CVT_EXP_BIAS    127

// destination integer width
`define CVT_INT_WIDTH   32

// internal signed exponent, wide enough for -126 .. +128
`define CVT_EXP_WIDTH   10

// request tag carried through the pipe
`define CVT_TAG_WIDTH   4

// right shift amount, covers 0 .. INT_WIDTH+1
`define CVT_SHIFT_WIDTH 6

`endif

// ==== logic/cvt_pipe_reg.sv ====
`timescale 1ns/1ps

// one pipeline stage: valid bit plus payload, held while en_i is low
module cvt_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     en_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // only the valid bit is control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            data_o <= data_i;  // bubbles load too, harmless
        end
    end

endmodule

// ==== logic/cvt_pkg.sv ====
`include "cvt_config.svh"

package cvt_pkg;

    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_signaling;
    } fp_class_t;

    // risc-v frm encoding
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_t;

    typedef struct packed {
        logic nv;
        logic dz;  // unused here, kept for fcsr layout
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic [`CVT_EXP_BITS+`CVT_MAN_BITS:0] operand;
        logic                                 is_unsigned;
        rnd_mode_t                            rnd_mode;
        logic [`CVT_TAG_WIDTH-1:0]            tag;
    } cvt_req_t;

    typedef struct packed {
        logic [`CVT_TAG_WIDTH-1:0]        tag;
        logic                             is_unsigned;
        rnd_mode_t                        rnd_mode;
        fp_class_t                        clss;
        logic                             sign;
        logic signed [`CVT_EXP_WIDTH-1:0] exponent;  // unbiased
        logic [`CVT_MAN_BITS:0]           mantissa;  // hidden bit on top
    } unpack_t;

    typedef struct packed {
        logic [`CVT_TAG_WIDTH-1:0]   tag;
        logic                        is_unsigned;
        rnd_mode_t                   rnd_mode;
        fp_class_t                   clss;
        logic                        sign;
        logic [2*`CVT_INT_WIDTH:0]   mant;  // 33 int bits . 32 fraction bits
        logic                        of_before_round;
    } align_t;

    typedef struct packed {
        logic [`CVT_TAG_WIDTH-1:0]   tag;
        logic                        is_unsigned;
        fp_class_t                   clss;
        logic                        sign;
        logic [`CVT_INT_WIDTH-1:0]   magnitude;
        logic                        inexact;
        logic                        of_before_round;
    } round_t;

    typedef struct packed {
        logic [`CVT_INT_WIDTH-1:0] result;
        fflags_t                   fflags;
        logic [`CVT_TAG_WIDTH-1:0] tag;
    } cvt_rsp_t;

endpackage

// ==== logic/cvt_resolve.sv ====
`timescale 1ns/1ps
`include "cvt_config.svh"

module cvt_resolve (
    input  cvt_pkg::round_t   stage_i,
    output cvt_pkg::cvt_rsp_t rsp_o
);

    import cvt_pkg::*;

    localparam int W = `CVT_INT_WIDTH;
    localparam logic [W-1:0] INT_MIN_MAG = {1'b1, {(W-1){1'b0}}};  // 2^(W-1)

    logic [W-1:0] int_result;     // two's complement of the magnitude
    logic         range_of;
    logic         neg_unsigned;
    logic         is_special;
    logic [W-1:0] special_result;
    fflags_t      special_flags;
    fflags_t      regular_flags;

    assign int_result = stage_i.sign ? (-stage_i.magnitude) : stage_i.magnitude;

    // signed range after rounding, unsigned overflow already folded in
    assign range_of = ~stage_i.is_unsigned
                    & (stage_i.sign ? (stage_i.magnitude > INT_MIN_MAG)
                                    : stage_i.magnitude[W-1]);

    assign neg_unsigned = stage_i.sign & stage_i.is_unsigned & (stage_i.magnitude != '0);

    assign is_special = stage_i.clss.is_nan
                      | stage_i.clss.is_inf
                      | stage_i.of_before_round
                      | range_of
                      | neg_unsigned;

    // nan saturates to the positive limit
    always_comb begin
        if (stage_i.sign && !stage_i.clss.is_nan) begin
            special_result = stage_i.is_unsigned ? '0 : INT_MIN_MAG;
        end else begin
            special_result = stage_i.is_unsigned ? '1 : ~INT_MIN_MAG;
        end
    end

    always_comb begin
        special_flags    = '0;
        special_flags.nv = 1'b1;
        regular_flags    = '0;
        regular_flags.nx = stage_i.inexact;
    end

    always_comb begin
        rsp_o.result = is_special ? special_result : int_result;
        rsp_o.fflags = is_special ? special_flags : regular_flags;
        rsp_o.tag    = stage_i.tag;
    end

endmodule

// ==== logic/cvt_round.sv ====
`timescale 1ns/1ps
`include "cvt_config.svh"

module cvt_round (
    input  cvt_pkg::align_t stage_i,
    output cvt_pkg::round_t stage_o
);

    import cvt_pkg::*;

    localparam int W = `CVT_INT_WIDTH;

    logic [W:0] int_part;     // integer bits incl. spare top bit
    logic       round_bit;
    logic       sticky_bit;
    logic       inexact;
    logic       round_up;
    logic [W:0] rounded;

    assign int_part   = stage_i.mant[2*W:W];
    assign round_bit  = stage_i.mant[W-1];
    assign sticky_bit = |stage_i.mant[W-2:0];
    assign inexact    = round_bit | sticky_bit;

    // direction depends on sign for RDN/RUP since we round the magnitude
    always_comb begin
        case (stage_i.rnd_mode)
            RNE:     round_up = round_bit & (sticky_bit | int_part[0]);
            RTZ:     round_up = 1'b0;
            RDN:     round_up = inexact & stage_i.sign;
            RUP:     round_up = inexact & ~stage_i.sign;
            RMM:     round_up = round_bit;  // ties away
            default: round_up = 1'b0;
        endcase
    end

    assign rounded = int_part + {{W{1'b0}}, round_up};

    always_comb begin
        stage_o.tag         = stage_i.tag;
        stage_o.is_unsigned = stage_i.is_unsigned;
        stage_o.clss        = stage_i.clss;
        stage_o.sign        = stage_i.sign;
        stage_o.magnitude   = rounded[W-1:0];
        stage_o.inexact     = inexact;
        // a carry out of W bits is beyond even the unsigned range
        stage_o.of_before_round = stage_i.of_before_round | rounded[W];
    end

endmodule

// ==== logic/cvt_unpack.sv ====
`timescale 1ns/1ps
`include "cvt_config.svh"

module cvt_unpack (
    input  cvt_pkg::cvt_req_t req_i,
    output cvt_pkg::unpack_t  stage_o
);

    import cvt_pkg::*;

    localparam int EB = `CVT_EXP_BITS;
    localparam int MB = `CVT_MAN_BITS;
    localparam int EW = `CVT_EXP_WIDTH;

    logic [EB-1:0] exp_field;
    logic [MB-1:0] man_field;
    logic          exp_zero;
    logic          exp_ones;
    logic          man_zero;
    logic [EB-1:0] exp_eff;  // subnormals behave as exponent field 1
    fp_class_t     clss;

    assign exp_field = req_i.operand[MB +: EB];
    assign man_field = req_i.operand[MB-1:0];

    assign exp_zero = (exp_field == '0);
    assign exp_ones = &exp_field;
    assign man_zero = (man_field == '0);

    always_comb begin
        clss.is_zero      = exp_zero & man_zero;
        clss.is_subnormal = exp_zero & ~man_zero;
        clss.is_normal    = ~exp_zero & ~exp_ones;
        clss.is_inf       = exp_ones & man_zero;
        clss.is_nan       = exp_ones & ~man_zero;
        clss.is_signaling = exp_ones & ~man_zero & ~man_field[MB-1];  // quiet bit clear
    end

    assign exp_eff = exp_zero ? EB'(1) : exp_field;

    always_comb begin
        stage_o.tag         = req_i.tag;
        stage_o.is_unsigned = req_i.is_unsigned;
        stage_o.rnd_mode    = req_i.rnd_mode;
        stage_o.clss        = clss;
        stage_o.sign        = req_i.operand[EB+MB];
        stage_o.exponent    = EW'(exp_eff) - EW'(`CVT_EXP_BIAS);
        stage_o.mantissa    = {~exp_zero, man_field};  // hidden bit
    end

endmodule

// ==== logic/fp_to_int_cvt.sv ====
`timescale 1ns/1ps

// float to int32 converter, four stage pipe
// unpack -> s0 -> align -> s1 -> round -> s2 -> resolve -> out
module fp_to_int_cvt (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  cvt_pkg::cvt_req_t req_i,
    output logic              valid_o,
    input  logic              ready_i,
    output cvt_pkg::cvt_rsp_t rsp_o
);

    import cvt_pkg::*;

    logic     stall;

    unpack_t  unpack_d;
    unpack_t  unpack_q;
    logic     valid_s0;

    align_t   align_d;
    align_t   align_q;
    logic     valid_s1;

    round_t   round_d;
    round_t   round_q;
    logic     valid_s2;

    cvt_rsp_t rsp_d;

    // whole pipe freezes when the head is blocked, no bubble squashing
    assign stall   = valid_o & ~ready_i;
    assign ready_o = ~stall;

    cvt_unpack u_unpack (.req_i(req_i), .stage_o(unpack_d));

    cvt_pipe_reg #(.payload_t(unpack_t)) u_reg_s0 (
        .clk(clk), .rst_i(rst_i), .en_i(~stall),
        .valid_i(valid_i), .data_i(unpack_d),
        .valid_o(valid_s0), .data_o(unpack_q)
    );

    cvt_align u_align (.stage_i(unpack_q), .stage_o(align_d));

    cvt_pipe_reg #(.payload_t(align_t)) u_reg_s1 (
        .clk(clk), .rst_i(rst_i), .en_i(~stall),
        .valid_i(valid_s0), .data_i(align_d),
        .valid_o(valid_s1), .data_o(align_q)
    );

    cvt_round u_round (.stage_i(align_q), .stage_o(round_d));

    cvt_pipe_reg #(.payload_t(round_t)) u_reg_s2 (
        .clk(clk), .rst_i(rst_i), .en_i(~stall),
        .valid_i(valid_s1), .data_i(round_d),
        .valid_o(valid_s2), .data_o(round_q)
    );

    cvt_resolve u_resolve (.stage_i(round_q), .rsp_o(rsp_d));

    // output register drives the response port directly
    cvt_pipe_reg #(.payload_t(cvt_rsp_t)) u_reg_out (
        .clk(clk), .rst_i(rst_i), .en_i(~stall),
        .valid_i(valid_s2), .data_i(rsp_d),
        .valid_o(valid_o), .data_o(rsp_o)
    );

endmodule

// ==== tb.f ====
+incdir+logic
logic/cvt_pkg.sv
logic/cvt_pipe_reg.sv
logic/cvt_unpack.sv
logic/cvt_align.sv
logic/cvt_round.sv
logic/cvt_resolve.sv
logic/fp_to_int_cvt.sv
verif/cvt_props.sv
verif/tb_fp_to_int_cvt.sv

// ==== verif/cvt_props.sv ====
`timescale 1ns/1ps

// checker bound into fp_to_int_cvt, holds a queue of expected responses
module cvt_props (
    input logic              clk,
    input logic              rst_i,
    input logic              valid_i,
    input logic              ready_o,
    input cvt_pkg::cvt_req_t req_i,
    input logic              valid_o,
    input logic              ready_i,
    input cvt_pkg::cvt_rsp_t rsp_o
);

    import cvt_pkg::*;

    localparam real TWO31 = 2147483648.0;

    cvt_rsp_t    exp_mem [0:15];
    logic [4:0]  wr_ptr;
    logic [4:0]  rd_ptr;
    logic [4:0]  pending;      // accepted but not yet delivered
    cvt_rsp_t    exp_head;
    logic [3:0]  lat_sr;       // where each accepted op should sit in the pipe
    logic        accept;
    logic        deliver;
    logic        stall;
    int unsigned fail_cnt = 0;

    // value based model: real value, then floor/ceil by mode, then range
    function automatic cvt_rsp_t expect_rsp(input cvt_req_t r);
        cvt_rsp_t    e;
        logic        sgn;
        int          ef;
        real         mag;
        real         val;
        real         fl;
        real         ce;
        real         diff;
        real         rnd;
        real         lo;
        real         hi;
        real         lim;
        logic [31:0] lo_bits;
        logic [31:0] hi_bits;
        e       = '0;
        e.tag   = r.tag;
        sgn     = r.operand[31];
        ef      = int'(r.operand[30:23]);
        lo      = r.is_unsigned ? 0.0 : -TWO31;
        hi      = r.is_unsigned ? (2.0 * TWO31 - 1.0) : (TWO31 - 1.0);
        lim     = r.is_unsigned ? (2.0 * TWO31) : TWO31;  // overflow before rounding
        lo_bits = r.is_unsigned ? 32'h0000_0000 : 32'h8000_0000;
        hi_bits = r.is_unsigned ? 32'hffff_ffff : 32'h7fff_ffff;
        if (ef == 255) begin
            e.fflags.nv = 1'b1;
            if (r.operand[22:0] != '0) begin
                e.result = hi_bits;  // nan
            end else begin
                e.result = sgn ? lo_bits : hi_bits;
            end
            return e;
        end
        if (ef == 0) begin
            mag = real'(r.operand[22:0]) * (2.0 ** (-149));
        end else begin
            mag = real'({1'b1, r.operand[22:0]}) * (2.0 ** (ef - 150));
        end
        if (mag >= lim) begin
            e.fflags.nv = 1'b1;
            e.result    = sgn ? lo_bits : hi_bits;
            return e;
        end
        val  = sgn ? -mag : mag;
        fl   = $floor(val);
        ce   = $ceil(val);
        diff = val - fl;
        case (r.rnd_mode)
            RNE: begin
                if (diff < 0.5) rnd = fl;
                else if (diff > 0.5) rnd = ce;
                else rnd = ($floor(fl / 2.0) * 2.0 == fl) ? fl : ce;  // tie to even
            end
            RDN: rnd = fl;
            RUP: rnd = ce;
            RMM: begin
                if (diff < 0.5) rnd = fl;
                else if (diff > 0.5) rnd = ce;
                else rnd = (val < 0.0) ? fl : ce;  // tie away from zero
            end
            default: rnd = (val < 0.0) ? ce : fl;  // toward zero
        endcase
        if (rnd < lo || rnd > hi) begin
            e.fflags.nv = 1'b1;
            e.result    = (rnd < lo) ? lo_bits : hi_bits;
        end else begin
            e.result    = 32'(longint'(rnd));
            e.fflags.nx = (fl != ce);
        end
        return e;
    endfunction

    assign accept   = valid_i & ready_o;
    assign deliver  = valid_o & ready_i;
    assign stall    = valid_o & ~ready_i;
    assign pending  = wr_ptr - rd_ptr;
    assign exp_head = exp_mem[rd_ptr[3:0]];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            lat_sr <= '0;
        end else begin
            if (accept) begin
                exp_mem[wr_ptr[3:0]] <= expect_rsp(req_i);
                wr_ptr <= wr_ptr + 5'd1;
            end
            if (deliver) rd_ptr <= rd_ptr + 5'd1;
            if (!stall) lat_sr <= {lat_sr[2:0], accept};  // four stages, frozen on stall
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst_i |=> (!valid_o && ready_o))
        else begin fail_cnt = fail_cnt + 1; $error("ERR pipe not idle after reset"); end

    a_latency: assert property (@(posedge clk) disable iff (rst_i) valid_o == lat_sr[3])
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERR valid_o got %h exp %h", $sampled(valid_o), $sampled(lat_sr[3]));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst_i)
        stall |=> (valid_o && $stable(rsp_o)))
        else begin fail_cnt = fail_cnt + 1; $error("ERR response not held while stalled"); end

    a_stall_ready: assert property (@(posedge clk) disable iff (rst_i) stall |-> !ready_o)
        else begin fail_cnt = fail_cnt + 1; $error("ERR request accepted while stalled"); end

    a_no_orphan: assert property (@(posedge clk) disable iff (rst_i) deliver |-> pending != 0)
        else begin fail_cnt = fail_cnt + 1; $error("ERR response with no request pending"); end

    a_result: assert property (@(posedge clk) disable iff (rst_i)
        deliver |-> rsp_o.result == exp_head.result)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERR rsp_o.result got %h exp %h",
                   $sampled(rsp_o.result), $sampled(exp_head.result));
        end

    a_fflags: assert property (@(posedge clk) disable iff (rst_i)
        deliver |-> rsp_o.fflags == exp_head.fflags)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERR rsp_o.fflags got %h exp %h",
                   $sampled(rsp_o.fflags), $sampled(exp_head.fflags));
        end

    a_tag: assert property (@(posedge clk) disable iff (rst_i)
        deliver |-> rsp_o.tag == exp_head.tag)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERR rsp_o.tag got %h exp %h", $sampled(rsp_o.tag), $sampled(exp_head.tag));
        end

endmodule

// ==== verif/tb_fp_to_int_cvt.sv ====
`timescale 1ns/1ps
`include "cvt_config.svh"

module tb_fp_to_int_cvt;

    import cvt_pkg::*;

    localparam int N_DIR           = 32;
    localparam int N_RAND          = 400;
    localparam int N_OPS           = N_DIR * 10 + N_RAND;  // directed ops run 5 modes x 2 types
    localparam int WATCHDOG_CYCLES = N_OPS * 40 + 500;

    // whole numbers, ties, tiny values, range edges, specials
    localparam logic [31:0] DIR_OPS [N_DIR] = '{
        32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000,
        32'h42F6_0000, 32'hC2F6_0000, 32'h4B7F_FFFF, 32'h4EFF_FFFF,
        32'hCF00_0000, 32'h4F00_0000, 32'h4F7F_FFFF, 32'h4F80_0000,
        32'h4020_0000, 32'hC020_0000, 32'h3FC0_0000, 32'hBFC0_0000,
        32'h3F00_0000, 32'hBF00_0000, 32'h3E80_0000, 32'hBE80_0000,
        32'h3F40_0000, 32'hC049_0FDB, 32'h402D_F854, 32'h0000_0001,
        32'h8040_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000,
        32'hFFA0_0000, 32'h7F7F_FFFF, 32'hDF00_0000, 32'hCF00_0001
    };

    logic                      clk;
    logic                      rst_i;
    logic                      valid_i;
    logic                      ready_o;
    cvt_req_t                  req_i;
    logic                      valid_o;
    logic                      ready_i;
    cvt_rsp_t                  rsp_o;
    logic                      bp_en;    // random back-pressure on the sink
    logic [`CVT_TAG_WIDTH-1:0] tag_cnt;

    fp_to_int_cvt UUT (
        .clk(clk), .rst_i(rst_i),
        .valid_i(valid_i), .ready_o(ready_o), .req_i(req_i),
        .valid_o(valid_o), .ready_i(ready_i), .rsp_o(rsp_o)
    );

    bind fp_to_int_cvt cvt_props u_props (
        .clk(clk), .rst_i(rst_i),
        .valid_i(valid_i), .ready_o(ready_o), .req_i(req_i),
        .valid_o(valid_o), .ready_i(ready_i), .rsp_o(rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // holds valid until the DUT takes the request
    task automatic send_op(input logic [31:0] op, input logic uns, input rnd_mode_t mode);
        cvt_req_t r;
        r.operand     = op;
        r.is_unsigned = uns;
        r.rnd_mode    = mode;
        r.tag         = tag_cnt;
        valid_i <= 1'b1;
        req_i   <= r;
        @(negedge clk);
        while (!ready_o) begin
            @(negedge clk);  // ready_o only moves on a rising edge
        end
        @(posedge clk);
        valid_i <= 1'b0;
        tag_cnt = tag_cnt + 1'b1;
    endtask

    function automatic logic [31:0] random_operand();
        logic [7:0] e;
        case ($urandom % 4)
            0: return $urandom;
            1, 2: begin
                e = 8'(117 + $urandom % 45);  // around the integer range
                return {1'($urandom), e, 23'($urandom)};
            end
            default: begin
                e = 8'(126 + $urandom % 4);  // short fractions with many ties
                return {1'($urandom), e, 23'($urandom) & 23'h7F_0000};
            end
        endcase
    endfunction

    always @(posedge clk) begin
        ready_i <= bp_en ? ($urandom % 3 != 0) : 1'b1;
    end

    always @(negedge clk) begin
        if (UUT.u_props.fail_cnt != 0) fail_stop("assertion failure reported by cvt_props");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_stop("watchdog expired before all responses arrived");
    end

    initial begin
        void'($urandom(97));
        rst_i    = 1'b1;
        valid_i  = 1'b0;
        req_i    = '0;
        ready_i  = 1'b1;
        bp_en    = 1'b0;
        tag_cnt  = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        // directed ops with the sink always ready
        for (int i = 0; i < N_DIR; i++) begin
            for (int u = 0; u < 2; u++) begin
                for (int m = 0; m < 5; m++) begin
                    send_op(DIR_OPS[i], 1'(u), rnd_mode_t'(m));
                end
            end
        end

        bp_en <= 1'b1;
        for (int k = 0; k < N_RAND; k++) begin
            send_op(random_operand(), 1'($urandom), rnd_mode_t'($urandom % 5));
        end

        @(negedge clk);
        while (UUT.u_props.pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (UUT.u_props.fail_cnt != 0) begin
            fail_stop("assertion failures were recorded");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
